/* design/regPkg.sv */
package regPkg;

  // --------------------
  // widths
  // --------------------
  localparam int dataWidth = 32;
  localparam int tagWidth  = 4;
  localparam int nameWidth = 5;

  localparam int checkpointSlots = 4; // depth of each line's rename ring

  // --------------------
  // types
  // --------------------
  typedef logic [dataWidth-1:0] dataT;
  typedef logic [tagWidth-1:0]  tagT;
  typedef logic [nameWidth-1:0] nameT;
  typedef logic [1:0]           ptrT; // indexes slots 0 to 3

  // a slot holding tagFree means the committed value is current
  localparam tagT  tagFree  = '0;
  localparam dataT dataFree = '0;

endpackage

/* design/checkpointCtrl.sv */
`timescale 1ns/1ps

module checkpointCtrl (
  input  logic        clk,
  input  logic        rst,
  input  logic        rdy,
  input  logic        branchDeeper,
  input  logic        branchFree,
  input  logic        misTaken,
  output regPkg::ptrT headPtr,
  output regPkg::ptrT tailPtr,
  output logic        goDeeper,
  output logic        rollBack,
  output logic        checkpointFull
);

  regPkg::ptrT count;
  logic        headAdvance;

  // --------------------
  // occupancy and strobe qualification
  // --------------------
  assign count = tailPtr - headPtr; // ring distance, wraps with the 2-bit pointers
  assign checkpointFull = (count == regPkg::ptrT'(regPkg::checkpointSlots - 1));

  // a misprediction overrides both other strobes in the same cycle
  assign rollBack    = rdy & misTaken;
  assign goDeeper    = rdy & branchDeeper & ~misTaken & ~checkpointFull;
  assign headAdvance = rdy & branchFree & ~misTaken & (count != '0);

  // --------------------
  // ring pointers
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      headPtr <= '0;
      tailPtr <= '0;
    end else begin
      if (headAdvance) begin
        headPtr <= headPtr + 1'b1; // oldest checkpoint resolved
      end
      if (rollBack) begin
        tailPtr <= headPtr; // back to the oldest checkpoint
      end else if (goDeeper) begin
        tailPtr <= tailPtr + 1'b1;
      end
    end
  end

  // the dispatcher must stall branches while the ring is full
  noDeeperWhenFull: assert property (
    @(posedge clk) disable iff (rst)
    (rdy && branchDeeper && !misTaken) |-> !checkpointFull
  ) else $error("branchDeeper while checkpointFull");

endmodule

/* design/regfileLine.sv */
`timescale 1ns/1ps

module regfileLine (
  input  logic         clk,
  input  logic         rst,
  input  logic         rdy,
  input  logic         renamEn,
  input  logic         goDeeper,
  input  logic         rollBack,
  input  regPkg::tagT  renamTag,
  input  regPkg::ptrT  headPtr,
  input  regPkg::ptrT  tailPtr,
  input  logic         aluWrtEn,
  input  logic         lsWrtEn,
  input  regPkg::tagT  aluWrtTag,
  input  regPkg::tagT  lsWrtTag,
  input  regPkg::dataT aluWrtData,
  input  regPkg::dataT lsWrtData,
  output regPkg::dataT data,
  output regPkg::tagT  tag
);

  regPkg::tagT slot    [regPkg::checkpointSlots];
  regPkg::tagT cleared [regPkg::checkpointSlots];
  regPkg::tagT headTag;
  regPkg::ptrT nextTail;

  assign nextTail = tailPtr + 1'b1; // wraps from slot 3 to slot 0
  assign headTag  = slot[headPtr];
  assign tag      = slot[tailPtr]; // the newest checkpoint is the live rename

  // --------------------
  // result bus clearing
  // --------------------
  for (genvar j = 0; j < regPkg::checkpointSlots; j++) begin : gClear
    assign cleared[j] = (aluWrtEn && slot[j] == aluWrtTag) ? regPkg::tagFree :
                        (lsWrtEn && slot[j] == lsWrtTag)   ? regPkg::tagFree :
                                                             slot[j];
  end

  // --------------------
  // slots and committed value
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < regPkg::checkpointSlots; i++) begin
        slot[i] <= regPkg::tagFree;
      end
      data <= regPkg::dataFree;
    end else if (rdy) begin
      for (int i = 0; i < regPkg::checkpointSlots; i++) begin
        slot[i] <= cleared[i];
      end
      if (renamEn) begin
        slot[tailPtr] <= renamTag;
      end
      // the new checkpoint inherits the tag from before this cycle's rename
      if (goDeeper) begin
        slot[nextTail] <= cleared[tailPtr];
      end
      if (aluWrtEn && headTag == aluWrtTag) begin
        data <= aluWrtData; // only the oldest checkpoint commits
      end else if (lsWrtEn && headTag == lsWrtTag) begin
        data <= lsWrtData;
      end
    end
  end

  // Rollback only moves tailPtr, so a flush in the same cycle as a new
  // checkpoint would leave the copied slot orphaned
  noDeeperOnRollBack: assert property (
    @(posedge clk) disable iff (rst)
    rollBack |-> !goDeeper
  ) else $error("goDeeper together with rollBack");

endmodule

/* design/operandRead.sv */
`timescale 1ns/1ps

module operandRead (
  input  regPkg::nameT name,
  input  regPkg::tagT  lineTag,
  input  regPkg::dataT lineData,
  input  logic         aluWrtEn,
  input  logic         lsWrtEn,
  input  regPkg::tagT  aluWrtTag,
  input  regPkg::tagT  lsWrtTag,
  input  regPkg::dataT aluWrtData,
  input  regPkg::dataT lsWrtData,
  output regPkg::tagT  tagOut,
  output regPkg::dataT dataOut
);

  always_comb begin
    if (name == '0) begin
      tagOut  = regPkg::tagFree; // register zero is hardwired
      dataOut = regPkg::dataFree;
    end else if (aluWrtEn && lineTag == aluWrtTag) begin
      tagOut  = regPkg::tagFree; // bypass the ALU result in the same cycle
      dataOut = aluWrtData;
    end else if (lsWrtEn && lineTag == lsWrtTag) begin
      tagOut  = regPkg::tagFree;
      dataOut = lsWrtData;
    end else begin
      tagOut  = lineTag;
      dataOut = lineData;
    end
  end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps

module regFile #(
  parameter int regCount = 32
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         rdy,
  input  logic         renamEn,
  input  regPkg::nameT renamName,
  input  regPkg::tagT  renamTag,
  input  regPkg::ptrT  headPtr,
  input  regPkg::ptrT  tailPtr,
  input  logic         goDeeper,
  input  logic         rollBack,
  input  logic         aluWrtEn,
  input  regPkg::tagT  aluWrtTag,
  input  regPkg::dataT aluWrtData,
  input  logic         lsWrtEn,
  input  regPkg::tagT  lsWrtTag,
  input  regPkg::dataT lsWrtData,
  input  regPkg::nameT regNameO,
  input  regPkg::nameT regNameT,
  output regPkg::dataT regDataO,
  output regPkg::tagT  regTagO,
  output regPkg::dataT regDataT,
  output regPkg::tagT  regTagT
);

  logic [regCount-1:0] lineRenamEn;
  regPkg::tagT         lineTag  [regCount];
  regPkg::dataT        lineData [regCount];
  regPkg::tagT         selTagO;
  regPkg::tagT         selTagT;
  regPkg::dataT        selDataO;
  regPkg::dataT        selDataT;

  // --------------------
  // rename decode
  // --------------------
  always_comb begin
    lineRenamEn = '0;
    if (int'(renamName) < regCount) begin
      lineRenamEn[renamName] = renamEn; // names past the file are dropped
    end
  end

  for (genvar j = 0; j < regCount; j++) begin : gLine
    regfileLine u_line (
      .clk       (clk),
      .rst       (rst),
      .rdy       (rdy),
      .renamEn   (lineRenamEn[j]),
      .goDeeper  (goDeeper),
      .rollBack  (rollBack),
      .renamTag  (renamTag),
      .headPtr   (headPtr),
      .tailPtr   (tailPtr),
      .aluWrtEn  (aluWrtEn),
      .lsWrtEn   (lsWrtEn),
      .aluWrtTag (aluWrtTag),
      .lsWrtTag  (lsWrtTag),
      .aluWrtData(aluWrtData),
      .lsWrtData (lsWrtData),
      .data      (lineData[j]),
      .tag       (lineTag[j])
    );
  end

  // --------------------
  // operand ports
  // --------------------
  assign selTagO  = (int'(regNameO) < regCount) ? lineTag[regNameO]  : regPkg::tagFree;
  assign selDataO = (int'(regNameO) < regCount) ? lineData[regNameO] : regPkg::dataFree;
  assign selTagT  = (int'(regNameT) < regCount) ? lineTag[regNameT]  : regPkg::tagFree;
  assign selDataT = (int'(regNameT) < regCount) ? lineData[regNameT] : regPkg::dataFree;

  operandRead u_readO (
    .name      (regNameO),
    .lineTag   (selTagO),
    .lineData  (selDataO),
    .aluWrtEn  (aluWrtEn),
    .lsWrtEn   (lsWrtEn),
    .aluWrtTag (aluWrtTag),
    .lsWrtTag  (lsWrtTag),
    .aluWrtData(aluWrtData),
    .lsWrtData (lsWrtData),
    .tagOut    (regTagO),
    .dataOut   (regDataO)
  );

  operandRead u_readT (
    .name      (regNameT),
    .lineTag   (selTagT),
    .lineData  (selDataT),
    .aluWrtEn  (aluWrtEn),
    .lsWrtEn   (lsWrtEn),
    .aluWrtTag (aluWrtTag),
    .lsWrtTag  (lsWrtTag),
    .aluWrtData(aluWrtData),
    .lsWrtData (lsWrtData),
    .tagOut    (regTagT),
    .dataOut   (regDataT)
  );

endmodule

/* design/renameStage.sv */
`timescale 1ns/1ps

module renameStage #(
  parameter int regCount = 32
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         rdy,
  input  logic         aluWrtEn,
  input  regPkg::tagT  aluWrtTag,
  input  regPkg::dataT aluWrtData,
  input  logic         lsWrtEn,
  input  regPkg::tagT  lsWrtTag,
  input  regPkg::dataT lsWrtData,
  input  regPkg::nameT regNameO,
  input  regPkg::nameT regNameT,
  input  logic         renamEn,
  input  regPkg::tagT  renamTag,
  input  regPkg::nameT renamName,
  input  logic         branchDeeper,
  input  logic         branchFree,
  input  logic         misTaken,
  output regPkg::dataT regDataO,
  output regPkg::tagT  regTagO,
  output regPkg::dataT regDataT,
  output regPkg::tagT  regTagT,
  output logic         checkpointFull
);

  regPkg::ptrT headPtr;
  regPkg::ptrT tailPtr;
  logic        goDeeper;
  logic        rollBack;

  checkpointCtrl u_ckpt (
    .clk           (clk),
    .rst           (rst),
    .rdy           (rdy),
    .branchDeeper  (branchDeeper),
    .branchFree    (branchFree),
    .misTaken      (misTaken),
    .headPtr       (headPtr),
    .tailPtr       (tailPtr),
    .goDeeper      (goDeeper),
    .rollBack      (rollBack),
    .checkpointFull(checkpointFull)
  );

  regFile #(
    .regCount(regCount)
  ) u_regFile (
    .clk       (clk),
    .rst       (rst),
    .rdy       (rdy),
    .renamEn   (renamEn),
    .renamName (renamName),
    .renamTag  (renamTag),
    .headPtr   (headPtr),
    .tailPtr   (tailPtr),
    .goDeeper  (goDeeper),
    .rollBack  (rollBack),
    .aluWrtEn  (aluWrtEn),
    .aluWrtTag (aluWrtTag),
    .aluWrtData(aluWrtData),
    .lsWrtEn   (lsWrtEn),
    .lsWrtTag  (lsWrtTag),
    .lsWrtData (lsWrtData),
    .regNameO  (regNameO),
    .regNameT  (regNameT),
    .regDataO  (regDataO),
    .regTagO   (regTagO),
    .regDataT  (regDataT),
    .regTagT   (regTagT)
  );

endmodule

/* tests/regModel.svh */
`ifndef REG_MODEL_SVH
`define REG_MODEL_SVH

// --------------------
// reference state
// --------------------
logic [3:0]  mSlot [32][4]; // rename tags per line and checkpoint slot
logic [31:0] mData [32];
logic [1:0]  mHead;
logic [1:0]  mTail;

function automatic logic [1:0] modelCount();
  return mTail - mHead; // ring distance
endfunction

function automatic logic modelFull();
  return modelCount() == 2'd3;
endfunction

task automatic modelReset();
  for (int r = 0; r < 32; r++) begin
    for (int s = 0; s < 4; s++) begin
      mSlot[r][s] = 4'h0;
    end
    mData[r] = 32'h0;
  end
  mHead = 2'd0;
  mTail = 2'd0;
endtask

// --------------------
// read rules
// --------------------
function automatic logic [3:0] expectTag(input logic [4:0] name);
  logic [3:0] t;
  t = mSlot[name][mTail];
  if (name == 5'd0) return 4'h0;
  if (aluWrtEn && t == aluWrtTag) return 4'h0; // bypassed result is ready
  if (lsWrtEn && t == lsWrtTag) return 4'h0;
  return t;
endfunction

function automatic logic [31:0] expectData(input logic [4:0] name);
  logic [3:0] t;
  t = mSlot[name][mTail];
  if (name == 5'd0) return 32'h0;
  if (aluWrtEn && t == aluWrtTag) return aluWrtData;
  if (lsWrtEn && t == lsWrtTag) return lsWrtData;
  return mData[name];
endfunction

// one rising edge of the register file with the inputs now driven
task automatic modelStep();
  logic [3:0] clr [4];
  logic [3:0] headTag;
  logic       deeper;
  logic       free;
  if (!rdy) return; // rdy low holds all state
  deeper = branchDeeper && !misTaken && !modelFull();
  free   = branchFree && !misTaken && modelCount() != 2'd0;
  for (int r = 0; r < 32; r++) begin
    headTag = mSlot[r][mHead];
    for (int s = 0; s < 4; s++) begin
      clr[s] = mSlot[r][s];
      if ((aluWrtEn && clr[s] == aluWrtTag) || (lsWrtEn && clr[s] == lsWrtTag)) clr[s] = 4'h0;
    end
    for (int s = 0; s < 4; s++) begin
      mSlot[r][s] = clr[s];
    end
    if (renamEn && renamName == r) mSlot[r][mTail] = renamTag;
    if (deeper) mSlot[r][mTail + 2'd1] = clr[mTail]; // copy before the rename
    if (aluWrtEn && headTag == aluWrtTag) mData[r] = aluWrtData;
    else if (lsWrtEn && headTag == lsWrtTag) mData[r] = lsWrtData;
  end
  if (misTaken) mTail = mHead;
  else if (deeper) mTail = mTail + 2'd1;
  if (free) mHead = mHead + 2'd1;
endtask

`endif

/* tests/renameStageTb.sv */
`timescale 1ns/1ps

module renameStageTb;

  logic        clk;
  logic        rst;
  logic        rdy;
  logic        aluWrtEn;
  logic [3:0]  aluWrtTag;
  logic [31:0] aluWrtData;
  logic        lsWrtEn;
  logic [3:0]  lsWrtTag;
  logic [31:0] lsWrtData;
  logic [4:0]  regNameO;
  logic [4:0]  regNameT;
  logic        renamEn;
  logic [3:0]  renamTag;
  logic [4:0]  renamName;
  logic        branchDeeper;
  logic        branchFree;
  logic        misTaken;
  logic [31:0] regDataO;
  logic [3:0]  regTagO;
  logic [31:0] regDataT;
  logic [3:0]  regTagT;
  logic        checkpointFull;
  logic [15:0] lfsr;
  int          waited;

  `include "regModel.svh"

  renameStage #(
    .regCount(32)
  ) u_dut (
    .clk(clk), .rst(rst), .rdy(rdy),
    .aluWrtEn(aluWrtEn), .aluWrtTag(aluWrtTag), .aluWrtData(aluWrtData),
    .lsWrtEn(lsWrtEn), .lsWrtTag(lsWrtTag), .lsWrtData(lsWrtData),
    .regNameO(regNameO), .regNameT(regNameT),
    .renamEn(renamEn), .renamTag(renamTag), .renamName(renamName),
    .branchDeeper(branchDeeper), .branchFree(branchFree), .misTaken(misTaken),
    .regDataO(regDataO), .regTagO(regTagO), .regDataT(regDataT), .regTagT(regTagT),
    .checkpointFull(checkpointFull)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // random source
  // --------------------
  function automatic logic nextBit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // taps 16 14 13 11
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], nextBit()};
    end
    return v;
  endfunction

  function automatic logic [3:0] takeTag();
    logic [3:0] t;
    t = 4'(takeBits(4));
    return (t == 4'h0) ? 4'h1 : t; // tag zero means free
  endfunction

  function automatic logic [4:0] takeName();
    return nextBit() ? 5'(takeBits(5)) : 5'(takeBits(3)); // favor low registers
  endfunction

  // --------------------
  // drive and check
  // --------------------
  task automatic clearInputs();
    rdy = 1'b1;
    aluWrtEn = 1'b0;
    aluWrtTag = 4'h0;
    aluWrtData = 32'h0;
    lsWrtEn = 1'b0;
    lsWrtTag = 4'h0;
    lsWrtData = 32'h0;
    regNameO = 5'd0;
    regNameT = 5'd0;
    renamEn = 1'b0;
    renamTag = 4'h0;
    renamName = 5'd0;
    branchDeeper = 1'b0;
    branchFree = 1'b0;
    misTaken = 1'b0;
  endtask

  task automatic driveRandom();
    rdy          = (takeBits(3) != 0);
    aluWrtEn     = nextBit();
    aluWrtTag    = takeTag();
    aluWrtData   = takeBits(32);
    lsWrtEn      = nextBit();
    lsWrtTag     = takeTag();
    lsWrtData    = takeBits(32);
    regNameO     = takeName();
    regNameT     = takeName();
    renamEn      = nextBit();
    renamTag     = takeTag();
    renamName    = takeName();
    misTaken     = (takeBits(4) == 0);
    branchFree   = (takeBits(2) == 0);
    branchDeeper = (takeBits(2) == 0) && (!modelFull() || misTaken); // never overflow
  endtask

  task automatic checkOutputs();
    assert (regTagO === expectTag(regNameO)) else begin
      $display("error: regTagO got %h expected %h", regTagO, expectTag(regNameO));
      $display("test failed");
      $fatal(1);
    end
    assert (regDataO === expectData(regNameO)) else begin
      $display("error: regDataO got %h expected %h", regDataO, expectData(regNameO));
      $display("test failed");
      $fatal(1);
    end
    assert (regTagT === expectTag(regNameT)) else begin
      $display("error: regTagT got %h expected %h", regTagT, expectTag(regNameT));
      $display("test failed");
      $fatal(1);
    end
    assert (regDataT === expectData(regNameT)) else begin
      $display("error: regDataT got %h expected %h", regDataT, expectData(regNameT));
      $display("test failed");
      $fatal(1);
    end
    assert (checkpointFull === modelFull()) else begin
      $display("error: checkpointFull got %h expected %h", checkpointFull, modelFull());
      $display("test failed");
      $fatal(1);
    end
  endtask

  // entered 1 ns after an edge with inputs driven, returns 1 ns after the next
  task automatic runCycle();
    #30;
    checkOutputs();
    @(posedge clk);
    modelStep();
    #1;
  endtask

  initial begin
    lfsr = 16'd4;
    clearInputs();
    rst = 1'b1;
    repeat (4) @(posedge clk);
    modelReset();
    #1;
    rst = 1'b0;

    // --------------------
    // branch, rename, mispredict
    // --------------------
    renamEn = 1'b1;
    renamName = 5'd5;
    renamTag = 4'h3;
    runCycle();
    clearInputs();
    branchDeeper = 1'b1;
    runCycle();
    clearInputs();
    renamEn = 1'b1;
    renamName = 5'd5;
    renamTag = 4'h7;
    regNameO = 5'd5;
    runCycle();
    clearInputs();
    misTaken = 1'b1;
    regNameO = 5'd5;
    runCycle();
    clearInputs();
    regNameO = 5'd5;
    #30;
    assert (regTagO === 4'h3) else begin
      $display("error: regTagO got %h expected %h", regTagO, 4'h3);
      $display("test failed");
      $fatal(1);
    end
    checkOutputs();
    @(posedge clk);
    modelStep();
    #1;

    // fill the ring, then release one checkpoint
    waited = 0;
    while (!checkpointFull) begin
      clearInputs();
      branchDeeper = 1'b1;
      runCycle();
      waited++;
      if (waited > 10) begin
        $display("timed out waiting for the checkpoint ring to fill");
        $display("test failed");
        $fatal(1);
      end
    end
    clearInputs();
    branchFree = 1'b1;
    runCycle();
    clearInputs();
    waited = 0;
    while (modelCount() != 2'd0) begin
      clearInputs();
      branchFree = 1'b1;
      runCycle();
      waited++;
      if (waited > 10) begin
        $display("timed out draining the checkpoint ring");
        $display("test failed");
        $fatal(1);
      end
    end
    branchFree = 1'b1; // no effect at count zero
    runCycle();

    // --------------------
    // random traffic
    // --------------------
    for (int c = 0; c < 3000; c++) begin
      driveRandom();
      runCycle();
    end
    $display("test passed");
    $finish;
  end

endmodule

/* project.f */
+incdir+tests
design/regPkg.sv
design/checkpointCtrl.sv
design/regfileLine.sv
design/operandRead.sv
design/regFile.sv
design/renameStage.sv
tests/renameStageTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module renameStageTb -o simv

out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -q "test passed"; then
  exit 0
else
  exit 1
fi
